// File: rtl/cu_ctrl_fsm.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module cu_ctrl_fsm (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  cu_isa_pkg::instr_class_e  cls_i,
	input  logic                      scoped_i,
	input  logic                      cls_valid_i,
	input  logic                      except_raised_i,
	input  cu_sys_pkg::except_code_e  except_code_i,
	input  logic                      all_done_i,
	output logic                      flush_o,
	output logic                      abort_o,
	output logic                      stall_o,
	output logic                      maint_req_o,
	output logic [`CU_NUM_MAINT-1:0]  maint_mask_o,
	output cu_sys_pkg::maint_type_e   maint_type_o
);
	import cu_isa_pkg::*;
	import cu_sys_pkg::*;

	typedef enum logic [2:0] {
		RESET,
		RUN,
		TRAP,
		MAINT,
		WAIT
	} state_e;

	state_e                   state_q;
	state_e                   state_d;
	logic                     env_flush_q;
	logic                     env_flush_d;
	logic [`CU_NUM_MAINT-1:0] mask_q;
	logic [`CU_NUM_MAINT-1:0] mask_d;
	maint_type_e              type_q;
	maint_type_e              type_d;
	except_code_e             code_q;
	logic [`CU_NUM_MAINT-1:0] tlb_mask;
	logic [`CU_NUM_MAINT-1:0] dmshr_mask;
	logic [`CU_NUM_MAINT-1:0] trap_mask;

	always_comb begin
		tlb_mask                = '0;
		tlb_mask[`CU_CH_L1TLB]  = 1'b1;
		tlb_mask[`CU_CH_L2TLB]  = 1'b1;
		dmshr_mask              = '0;
		dmshr_mask[`CU_CH_DMSHR] = 1'b1;
	end

	// Structures touched by each cause group
	always_comb begin
		case (code_q)
			E_I_ADDR_MISALIGNED, E_I_ACCESS_FAULT, E_I_PAGE_FAULT:
				trap_mask = tlb_mask;
			E_LD_ADDR_MISALIGNED, E_LD_ACCESS_FAULT, E_LD_PAGE_FAULT,
			E_ST_ADDR_MISALIGNED, E_ST_ACCESS_FAULT, E_ST_PAGE_FAULT:
				trap_mask = dmshr_mask;
			default:
				trap_mask = '0;
		endcase
	end

	always_comb begin
		state_d     = state_q;
		mask_d      = mask_q;
		type_d      = type_q;
		env_flush_d = 1'b0;
		case (state_q)
			RESET: state_d = WAIT;
			RUN: begin
				// Exceptions win over the decoded class
				if (except_raised_i) begin
					state_d = TRAP;
				end else if (cls_valid_i) begin
					case (cls_i)
						CLS_FENCE_I: begin
							state_d = MAINT;
							mask_d  = tlb_mask;
							type_d  = MT_ALL;
						end
						CLS_SFENCE: begin
							state_d = MAINT;
							mask_d  = '1;
							type_d  = scoped_i ? MT_ASID : MT_ALL;
						end
						CLS_ECALL, CLS_EBREAK: env_flush_d = 1'b1;
						default: state_d = RUN;
					endcase
				end
			end
			TRAP:    state_d = (|trap_mask) ? WAIT : RUN;
			MAINT:   state_d = WAIT;
			WAIT: begin
				if (all_done_i) begin
					state_d = RUN;
				end
			end
			default: state_d = RESET;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= RESET;
			env_flush_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			env_flush_q <= env_flush_d;
		end
	end

	always_ff @(posedge clk_i) begin
		mask_q <= mask_d;
		type_q <= type_d;
		if (state_q == RUN && except_raised_i) begin
			code_q <= except_code_i;
		end
	end

	always_comb begin
		flush_o      = env_flush_q;
		abort_o      = 1'b0;
		stall_o      = (state_q != RUN);
		maint_req_o  = 1'b0;
		maint_mask_o = '0;
		maint_type_o = MT_NONE;
		case (state_q)
			RESET: begin
				flush_o      = 1'b1;
				maint_req_o  = 1'b1;
				maint_mask_o = '1;
				maint_type_o = MT_ALL;
			end
			TRAP: begin
				flush_o      = 1'b1;
				abort_o      = (code_q == E_ILLEGAL_INSTR);
				maint_req_o  = |trap_mask;
				maint_mask_o = trap_mask;
				maint_type_o = (|trap_mask) ? MT_ALL : MT_NONE;
			end
			MAINT: begin
				maint_req_o  = 1'b1;
				maint_mask_o = mask_q;
				maint_type_o = type_q;
			end
			default: maint_type_o = MT_NONE;
		endcase
	end

endmodule

// File: rtl/cu_isa_pkg.sv
package cu_isa_pkg;

	// RV32 major opcodes seen by the control unit
	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_STORE    = 7'b0100011,
		OPC_BRANCH   = 7'b1100011,
		OPC_JAL      = 7'b1101111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	// Coarse class of an issued instruction
	typedef enum logic [2:0] {
		CLS_OTHER   = 3'd0,
		CLS_JUMP    = 3'd1,
		CLS_BRANCH  = 3'd2,
		CLS_LDST    = 3'd3,
		CLS_FENCE_I = 3'd4,
		CLS_SFENCE  = 3'd5,
		CLS_ECALL   = 3'd6,
		CLS_EBREAK  = 3'd7
	} instr_class_e;

	// MISC-MEM funct3 for FENCE.I
	localparam logic [2:0] F3_FENCE_I = 3'b001;

	// SYSTEM funct3 shared by ECALL, EBREAK and SFENCE.VMA
	localparam logic [2:0] F3_PRIV = 3'b000;

	localparam logic [6:0]  F7_SFENCE_VMA = 7'b0001001;
	localparam logic [11:0] F12_ECALL     = 12'h000;
	localparam logic [11:0] F12_EBREAK    = 12'h001;

endpackage

// File: rtl/cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Instruction word
`define CU_ILEN       32

// Field positions inside the instruction word
`define CU_OPC_MSB    6
`define CU_OPC_LSB    0
`define CU_F3_MSB     14
`define CU_F3_LSB     12
`define CU_RS2_MSB    24
`define CU_RS2_LSB    20
`define CU_F7_MSB     31
`define CU_F7_LSB     25
`define CU_F12_MSB    31
`define CU_F12_LSB    20

// Maintenance channels, one per memory structure
`define CU_NUM_MAINT  3
`define CU_CH_L1TLB   0
`define CU_CH_L2TLB   1
`define CU_CH_DMSHR   2

`endif

// File: rtl/cu_sys_pkg.sv
package cu_sys_pkg;

	// Exception causes, numbered as in the privileged spec
	typedef enum logic [3:0] {
		E_I_ADDR_MISALIGNED  = 4'd0,
		E_I_ACCESS_FAULT     = 4'd1,
		E_ILLEGAL_INSTR      = 4'd2,
		E_LD_ADDR_MISALIGNED = 4'd4,
		E_LD_ACCESS_FAULT    = 4'd5,
		E_ST_ADDR_MISALIGNED = 4'd6,
		E_ST_ACCESS_FAULT    = 4'd7,
		E_I_PAGE_FAULT       = 4'd12,
		E_LD_PAGE_FAULT      = 4'd13,
		E_ST_PAGE_FAULT      = 4'd15
	} except_code_e;

	// How a structure is to be cleared
	typedef enum logic [1:0] {
		MT_NONE = 2'd0,
		MT_ALL  = 2'd1,
		MT_ASID = 2'd2
	} maint_type_e;

endpackage

// File: rtl/cu_top.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module cu_top (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic [`CU_ILEN-1:0]      instr_i,
	input  logic                     instr_valid_i,
	input  logic                     except_raised_i,
	input  cu_sys_pkg::except_code_e except_code_i,
	input  logic [`CU_NUM_MAINT-1:0] maint_done_i,
	output logic                     flush_o,
	output logic                     abort_o,
	output logic                     stall_o,
	output logic [`CU_NUM_MAINT-1:0] maint_busy_o,
	output cu_sys_pkg::maint_type_e  maint_type_o [`CU_NUM_MAINT]
);
	import cu_isa_pkg::*;
	import cu_sys_pkg::*;

	instr_class_e             cls;
	logic                     scoped;
	logic                     cls_valid;
	logic                     fsm_stall;
	logic                     maint_req;
	logic [`CU_NUM_MAINT-1:0] maint_mask;
	maint_type_e              req_type;
	logic                     all_done;

	instr_classifier u_classifier (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_i       (instr_i),
		.instr_valid_i (instr_valid_i),
		.stall_i       (fsm_stall),
		.cls_o         (cls),
		.scoped_o      (scoped),
		.cls_valid_o   (cls_valid)
	);

	cu_ctrl_fsm u_fsm (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.cls_i           (cls),
		.scoped_i        (scoped),
		.cls_valid_i     (cls_valid),
		.except_raised_i (except_raised_i),
		.except_code_i   (except_code_i),
		.all_done_i      (all_done),
		.flush_o         (flush_o),
		.abort_o         (abort_o),
		.stall_o         (fsm_stall),
		.maint_req_o     (maint_req),
		.maint_mask_o    (maint_mask),
		.maint_type_o    (req_type)
	);

	// One clear channel per memory structure
	for (genvar k = 0; k < `CU_NUM_MAINT; k++) begin : g_chan
		maint_channel u_chan (
			.clk_i      (clk_i),
			.rst_n_i    (rst_n_i),
			.req_i      (maint_req & maint_mask[k]),
			.type_i     (req_type),
			.done_i     (maint_done_i[k]),
			.busy_o     (maint_busy_o[k]),
			.clr_type_o (maint_type_o[k])
		);
	end

	maint_join u_join (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.busy_i     (maint_busy_o),
		.req_seen_i (maint_req),
		.all_done_o (all_done)
	);

	// Issue waits on the FSM and on every open clear
	assign stall_o = fsm_stall | (|maint_busy_o);

endmodule

// File: rtl/instr_classifier.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module instr_classifier (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic [`CU_ILEN-1:0]      instr_i,
	input  logic                     instr_valid_i,
	input  logic                     stall_i,
	output cu_isa_pkg::instr_class_e cls_o,
	output logic                     scoped_o,
	output logic                     cls_valid_o
);
	import cu_isa_pkg::*;

	opcode_e      opcode;
	logic [2:0]   funct3;
	logic [6:0]   funct7;
	logic [11:0]  funct12;
	logic [4:0]   rs2;
	instr_class_e cls_d;
	logic         take;

	assign opcode  = opcode_e'(instr_i[`CU_OPC_MSB:`CU_OPC_LSB]);
	assign funct3  = instr_i[`CU_F3_MSB:`CU_F3_LSB];
	assign funct7  = instr_i[`CU_F7_MSB:`CU_F7_LSB];
	assign funct12 = instr_i[`CU_F12_MSB:`CU_F12_LSB];
	assign rs2     = instr_i[`CU_RS2_MSB:`CU_RS2_LSB];

	// Strobes during a stall are dropped
	assign take = instr_valid_i & ~stall_i;

	always_comb begin
		cls_d = CLS_OTHER;
		case (opcode)
			OPC_JAL:             cls_d = CLS_JUMP;
			OPC_BRANCH:          cls_d = CLS_BRANCH;
			OPC_LOAD, OPC_STORE: cls_d = CLS_LDST;
			OPC_MISC_MEM: begin
				// Plain FENCE stays in CLS_OTHER
				if (funct3 == F3_FENCE_I) begin
					cls_d = CLS_FENCE_I;
				end
			end
			OPC_SYSTEM: begin
				if (funct3 == F3_PRIV) begin
					if (funct7 == F7_SFENCE_VMA) begin
						cls_d = CLS_SFENCE;
					end else if (funct12 == F12_ECALL) begin
						cls_d = CLS_ECALL;
					end else if (funct12 == F12_EBREAK) begin
						cls_d = CLS_EBREAK;
					end
				end
			end
			default: cls_d = CLS_OTHER;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cls_valid_o <= 1'b0;
		end else begin
			cls_valid_o <= take;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			cls_o    <= cls_d;
			// Non-zero rs2 narrows SFENCE.VMA to one address space
			scoped_o <= (cls_d == CLS_SFENCE) && (rs2 != 5'd0);
		end
	end

endmodule

// File: rtl/maint_channel.sv
`timescale 1ns/1ps

module maint_channel (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    req_i,
	input  cu_sys_pkg::maint_type_e type_i,
	input  logic                    done_i,
	output logic                    busy_o,
	output cu_sys_pkg::maint_type_e clr_type_o
);
	import cu_sys_pkg::*;

	// Clear level stays up until the structure answers
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_o     <= 1'b0;
			clr_type_o <= MT_NONE;
		end else if (req_i) begin
			busy_o     <= 1'b1;
			clr_type_o <= type_i;
		end else if (busy_o && done_i) begin
			busy_o     <= 1'b0;
			clr_type_o <= MT_NONE;
		end
	end

endmodule

// File: rtl/maint_join.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module maint_join (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic [`CU_NUM_MAINT-1:0] busy_i,
	input  logic                     req_seen_i,
	output logic                     all_done_o
);

	logic pending_q;

	// Busy flags rise one edge after the request, so the check starts then
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pending_q  <= 1'b0;
			all_done_o <= 1'b0;
		end else begin
			all_done_o <= 1'b0;
			if (req_seen_i) begin
				pending_q <= 1'b1;
			end else if (pending_q && !(|busy_i)) begin
				pending_q  <= 1'b0;
				all_done_o <= 1'b1;
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the cu_top testbench with Verilator, run it and look for the pass line in the log

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_cu_top -o tb_cu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_cu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: src.f
+incdir+rtl
rtl/cu_isa_pkg.sv
rtl/cu_sys_pkg.sv
rtl/instr_classifier.sv
rtl/cu_ctrl_fsm.sv
rtl/maint_channel.sv
rtl/maint_join.sv
rtl/cu_top.sv
verification/tb_clk_gen.sv
verification/cu_top_chk.sv
verification/tb_cu_top.sv

// File: verification/cu_patterns.txt
# test instr exc code mask type flush abort
# instr and code in hex, mask in binary with DMSHR on the left, type 0 none 1 all 2 asid
fence_i          0000100f 0 0 011 1 0 0
sfence_all       12000073 0 0 111 1 0 0
sfence_asid      12500073 0 0 111 2 0 0
ecall            00000073 0 0 000 0 1 0
ebreak           00100073 0 0 000 0 1 0
jal              008000ef 0 0 000 0 0 0
beq              00000063 0 0 000 0 0 0
lw               00012083 0 0 000 0 0 0
sw               00112023 0 0 000 0 0 0
i_misaligned     00000013 1 0 011 1 1 0
ld_access_fault  00000013 1 5 100 1 1 0
st_page_fault    00000013 1 f 100 1 1 0
illegal_instr    00000013 1 2 000 0 1 1

// File: verification/cu_top_chk.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module cu_top_chk (
	input logic                     clk_i,
	input logic                     rst_n_i,
	input logic                     stall_i,
	input logic                     abort_i,
	input logic [`CU_NUM_MAINT-1:0] busy_i
);

	// An open clear must hold issue back
	a_stall_covers_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(|busy_i) |-> stall_i)
		else $error("stall_o low while a maintenance channel is busy");

	// Abort is a single-cycle pulse
	a_abort_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(abort_i && $past(abort_i)))
		else $error("abort_o high for two cycles in a row");

	a_idle_in_reset: assert property (@(posedge clk_i) rst_n_i || (busy_i == '0))
		else $error("maintenance channel busy during reset");

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	// 100 ns period
	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// Reset held for 16 cycles, released just after an edge
	initial begin
		rst_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

// File: verification/tb_cu_top.sv
`timescale 1ns/1ps
`include "cu_params.svh"

module tb_cu_top;
	import cu_sys_pkg::*;

	localparam int DELAY_DEPTH = 64;

	logic                     clk;
	logic                     rst_n;
	logic [`CU_ILEN-1:0]      instr;
	logic                     instr_valid;
	logic                     except_raised;
	except_code_e             except_code;
	logic [`CU_NUM_MAINT-1:0] maint_done;
	logic                     flush;
	logic                     abort;
	logic                     stall;
	logic [`CU_NUM_MAINT-1:0] maint_busy;
	maint_type_e              maint_type [`CU_NUM_MAINT];

	// Pattern table, one entry per test
	string                    names [$];
	logic [`CU_ILEN-1:0]      instrs [$];
	logic                     excs [$];
	except_code_e             codes [$];
	logic [`CU_NUM_MAINT-1:0] masks [$];
	maint_type_e              types [$];
	logic [1:0]               flush_abort [$];

	// What the DUT did during the current test
	logic [`CU_NUM_MAINT-1:0] obs_mask;
	maint_type_e              obs_type [`CU_NUM_MAINT];
	logic                     obs_flush;
	logic                     obs_abort;

	// Done delays per channel, drawn once from the seeded generator
	int unsigned done_delay [`CU_NUM_MAINT][DELAY_DEPTH];

	int mask_errs = 0;
	int type_errs = 0;
	int bit_errs = 0;
	int other_errs = 0;
	int cycles = 0;
	int limit = 200;

	tb_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	cu_top DUT (
		.clk_i           (clk),
		.rst_n_i         (rst_n),
		.instr_i         (instr),
		.instr_valid_i   (instr_valid),
		.except_raised_i (except_raised),
		.except_code_i   (except_code),
		.maint_done_i    (maint_done),
		.flush_o         (flush),
		.abort_o         (abort),
		.stall_o         (stall),
		.maint_busy_o    (maint_busy),
		.maint_type_o    (maint_type)
	);

	bind cu_top cu_top_chk u_chk (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.stall_i (stall_o),
		.abort_i (abort_o),
		.busy_i  (maint_busy_o)
	);

	// Each structure answers its clear after 1 to 8 cycles
	for (genvar k = 0; k < `CU_NUM_MAINT; k++) begin : g_resp
		logic        done;
		int unsigned delay;
		int          idx;

		assign maint_done[k] = done;

		initial begin
			done = 1'b0;
			idx  = 0;
			forever begin
				@(negedge clk);
				if (maint_busy[k]) begin
					delay = done_delay[k][idx % DELAY_DEPTH];
					idx++;
					repeat (delay) @(posedge clk);
					#1 done = 1'b1;
					@(posedge clk);
					#1 done = 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_mask(input string name, input logic [`CU_NUM_MAINT-1:0] exp, act);
		if (act !== exp) begin
			$display("Error %s: busy mask expected %b actual %b", name, exp, act);
			mask_errs++;
		end
	endtask

	task automatic check_type(input string name, input maint_type_e exp, act);
		if (act !== exp) begin
			$display("Error %s: clear type expected %s actual %s", name, exp.name(), act.name());
			type_errs++;
		end
	endtask

	task automatic check_bit(input string name, input string what, input logic exp, act);
		if (act !== exp) begin
			$display("Error %s: %s expected %b actual %b", name, what, exp, act);
			bit_errs++;
		end
	endtask

	task automatic clear_observed();
		obs_mask  = '0;
		obs_flush = 1'b0;
		obs_abort = 1'b0;
		for (int k = 0; k < `CU_NUM_MAINT; k++) begin
			obs_type[k] = MT_NONE;
		end
	endtask

	// Called at the falling edge, where every output is settled
	task automatic sample_outputs();
		obs_mask  = obs_mask | maint_busy;
		obs_flush = obs_flush | flush;
		obs_abort = obs_abort | abort;
		for (int k = 0; k < `CU_NUM_MAINT; k++) begin
			if (maint_busy[k]) begin
				obs_type[k] = maint_type[k];
			end
		end
		if (!stall && (|maint_busy)) begin
			$display("stall_o fell while a maintenance channel was still busy");
			other_errs++;
		end
	endtask

	task automatic watch_until_idle(input int min_cycles);
		int n;
		n = 0;
		while (n < min_cycles || stall) begin
			@(negedge clk);
			sample_outputs();
			n++;
		end
	endtask

	task automatic check_outcome(input string name, input logic [`CU_NUM_MAINT-1:0] mask,
			input maint_type_e mtype, input logic [1:0] fa);
		check_mask(name, mask, obs_mask);
		for (int k = 0; k < `CU_NUM_MAINT; k++) begin
			if (mask[k]) begin
				check_type(name, mtype, obs_type[k]);
			end
		end
		// Idle channels drive no clear kind
		for (int k = 0; k < `CU_NUM_MAINT; k++) begin
			check_type(name, MT_NONE, maint_type[k]);
		end
		check_bit(name, "flush_o", fa[1], obs_flush);
		check_bit(name, "abort_o", fa[0], obs_abort);
	endtask

	initial begin
		int           fd;
		int           e;
		int           t;
		int           f;
		int           a;
		string        line;
		string        nm;
		logic [31:0]  ins;
		logic [3:0]   c;
		logic [`CU_NUM_MAINT-1:0] m;

		void'($urandom(32'h3644));
		for (int k = 0; k < `CU_NUM_MAINT; k++) begin
			for (int j = 0; j < DELAY_DEPTH; j++) begin
				done_delay[k][j] = $urandom_range(8, 1);
			end
		end
		instr         = '0;
		instr_valid   = 1'b0;
		except_raised = 1'b0;
		except_code   = E_I_ADDR_MISALIGNED;

		fd = $fopen("verification/cu_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file verification/cu_patterns.txt");
			other_errs++;
		end else begin
			// Comment and blank lines do not match all eight fields
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "%s %h %d %h %b %d %d %d", nm, ins, e, c, m, t, f, a) == 8) begin
					names.push_back(nm);
					instrs.push_back(ins);
					excs.push_back(e[0]);
					codes.push_back(except_code_e'(c));
					masks.push_back(m);
					types.push_back(maint_type_e'(t[1:0]));
					flush_abort.push_back({f[0], a[0]});
				end
			end
			$fclose(fd);
		end
		if (names.size() == 0) begin
			$display("No test patterns were read");
			other_errs++;
		end
		limit = 64 * names.size() + 200;

		// Reset clears every structure and flushes the pipeline
		@(posedge rst_n);
		clear_observed();
		watch_until_idle(3);
		check_outcome("reset", '1, MT_ALL, 2'b10);

		foreach (names[i]) begin
			clear_observed();
			@(posedge clk);
			#1;
			instr         = instrs[i];
			instr_valid   = 1'b1;
			except_raised = excs[i];
			except_code   = codes[i];
			@(negedge clk);
			sample_outputs();
			@(posedge clk);
			#1;
			instr_valid   = 1'b0;
			except_raised = 1'b0;
			watch_until_idle(5);
			check_outcome(names[i], masks[i], types[i], flush_abort[i]);
		end

		$display("Errors: mask %0d, type %0d, bit %0d, other %0d",
			mask_errs, type_errs, bit_errs, other_errs);
		if (mask_errs + type_errs + bit_errs + other_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
